/* hw/axil_consts.svh */
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------
`define AXIL_ADDR_WIDTH     (32)
`define AXIL_DATA_WIDTH     (32)

// --------------------------------------------------
// register map
// --------------------------------------------------
`define AXIL_NUM_SLOTS      (4)
`define AXIL_REGS_PER_SLOT  (4)
// region field of every mapped address (0x43c0_0000 to 0x43c0_00ff)
`define AXIL_MAP_BASE       (24'h43c000)

`endif

/* hw/axil_pkg.sv */
`include "axil_consts.svh"

package axil_pkg;

    // write response codes
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;

    // one strobe bit per byte lane
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;

endpackage

/* hw/regmap_pkg.sv */
`include "axil_consts.svh"

package regmap_pkg;

    // --------------------------------------------------
    // address layout
    // --------------------------------------------------
    typedef struct packed
    {
        logic [`AXIL_ADDR_WIDTH-9:0] region;
        logic [1:0]                  slot;
        logic [3:0]                  reg_idx;
        logic [1:0]                  byte_off;
    } addr_fields_t;

    // same word, raw or split into fields
    typedef union packed
    {
        logic [`AXIL_ADDR_WIDTH-1:0] raw;
        addr_fields_t                fields;
    } addr_u;

    // slots 0..N-1, sink at index N
    typedef logic [$clog2(`AXIL_NUM_SLOTS + 1)-1:0] target_t;

    // register bank of one slot, register 0 in the low word
    typedef axil_pkg::data_t [`AXIL_REGS_PER_SLOT-1:0] slot_regs_t;

endpackage

/* hw/axil_wr_if.sv */
`timescale 1ns/1ps

interface axil_wr_if;

    import axil_pkg::*;
    import regmap_pkg::*;

    // write address
    addr_u  awaddr;
    logic   awvalid;
    logic   awready;

    // write data
    data_t  wdata;
    strb_t  wstrb;
    logic   wvalid;
    logic   wready;

    // write response
    resp_e  bresp;
    logic   bvalid;
    logic   bready;

    modport initiator
    (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport target
    (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

/* hw/axil_wr_router.sv */
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_wr_router
(
    input  logic                aclk,
    input  logic                aresetn,

    input  regmap_pkg::addr_u   awaddr,
    input  logic                awvalid,
    input  logic                wvalid,
    input  axil_pkg::data_t     wdata,
    input  axil_pkg::strb_t     wstrb,

    // top-level B handshake done
    input  logic                resp_done,

    axil_wr_if.initiator        slot_ports [`AXIL_NUM_SLOTS],
    axil_wr_if.initiator        sink_port
);

    import regmap_pkg::*;

    localparam target_t SINK_TARGET = target_t'(`AXIL_NUM_SLOTS);

    target_t                    dec_target;
    logic [`AXIL_NUM_SLOTS:0]   hit;
    logic                       locked;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb
    begin
        if (awaddr.fields.region == `AXIL_MAP_BASE)
            dec_target = target_t'(awaddr.fields.slot);
        else
            dec_target = SINK_TARGET;

        // nothing new goes out while a write is in flight
        for (int t = 0; t <= `AXIL_NUM_SLOTS; t++)
            hit[t] = !locked && (dec_target == target_t'(t));
    end

    // held from the forwarding edge until the B handshake
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            locked <= 1'b0;
        else if (resp_done)
            locked <= 1'b0;
        else if (awvalid && wvalid && !locked)
            locked <= 1'b1;
    end

    // --------------------------------------------------
    // steering
    // --------------------------------------------------
    genvar i;
    generate
        for (i = 0; i < `AXIL_NUM_SLOTS; i++)
        begin : g_slot
            assign slot_ports[i].awaddr  = awaddr;
            assign slot_ports[i].wdata   = wdata;
            assign slot_ports[i].wstrb   = wstrb;
            assign slot_ports[i].awvalid = awvalid && hit[i];
            assign slot_ports[i].wvalid  = wvalid && hit[i];
        end
    endgenerate

    assign sink_port.awaddr  = awaddr;
    assign sink_port.wdata   = wdata;
    assign sink_port.wstrb   = wstrb;
    assign sink_port.awvalid = awvalid && hit[`AXIL_NUM_SLOTS];
    assign sink_port.wvalid  = wvalid && hit[`AXIL_NUM_SLOTS];

endmodule

/* hw/axil_reg_slot.sv */
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_reg_slot
(
    input  logic                    aclk,
    input  logic                    aresetn,

    axil_wr_if.target               bus,

    output regmap_pkg::slot_regs_t  regs
);

    import axil_pkg::*;

    localparam int IDX_BITS  = $clog2(`AXIL_REGS_PER_SLOT);
    localparam int NUM_BYTES = `AXIL_DATA_WIDTH / 8;

    typedef enum logic [1:0]
    {
        IDLE,
        RESP,
        HOLD
    } state_e;

    state_e                 state;
    logic                   accept;
    logic                   idx_ok;
    logic [IDX_BITS-1:0]    widx;

    assign accept = (state == IDLE) && bus.awvalid && bus.wvalid;
    assign idx_ok = bus.awaddr.fields.reg_idx < `AXIL_REGS_PER_SLOT;
    assign widx   = bus.awaddr.fields.reg_idx[IDX_BITS-1:0];

    // --------------------------------------------------
    // handshake FSM
    // --------------------------------------------------
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state       <= IDLE;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
            bus.bresp   <= OKAY;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state       <= RESP;
                        bus.awready <= 1'b1;
                        bus.wready  <= 1'b1;
                        bus.bresp   <= idx_ok ? OKAY : SLVERR;
                    end
                end
                RESP:
                begin
                    state       <= HOLD;
                    bus.awready <= 1'b0;
                    bus.wready  <= 1'b0;
                    bus.bvalid  <= 1'b1;
                end
                HOLD:
                begin
                    if (bus.bready)
                    begin
                        state      <= IDLE;
                        bus.bvalid <= 1'b0;
                        bus.bresp  <= OKAY;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // byte-lane merge, same edge as the readies
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            regs <= '0;
        else if (accept && idx_ok)
        begin
            for (int b = 0; b < NUM_BYTES; b++)
                if (bus.wstrb[b])
                    regs[widx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
    end

endmodule

/* hw/axil_decerr_sink.sv */
`timescale 1ns/1ps

module axil_decerr_sink
(
    input  logic        aclk,
    input  logic        aresetn,

    axil_wr_if.target   bus
);

    import axil_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        RESP,
        HOLD
    } state_e;

    state_e state;

    // payload is dropped, only the handshake runs
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state       <= IDLE;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
            bus.bresp   <= OKAY;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (bus.awvalid && bus.wvalid)
                    begin
                        state       <= RESP;
                        bus.awready <= 1'b1;
                        bus.wready  <= 1'b1;
                    end
                end
                RESP:
                begin
                    state       <= HOLD;
                    bus.awready <= 1'b0;
                    bus.wready  <= 1'b0;
                    bus.bvalid  <= 1'b1;
                    bus.bresp   <= DECERR;
                end
                HOLD:
                begin
                    if (bus.bready)
                    begin
                        state      <= IDLE;
                        bus.bvalid <= 1'b0;
                        bus.bresp  <= OKAY;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

/* hw/axil_resp_slice.sv */
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_resp_slice
(
    input  logic            aclk,
    input  logic            aresetn,

    axil_wr_if.initiator    slot_ports [`AXIL_NUM_SLOTS],
    axil_wr_if.initiator    sink_port,

    output logic            awready,
    output logic            wready,
    output axil_pkg::resp_e bresp,
    output logic            bvalid,
    input  logic            bready,

    output logic            resp_done
);

    import axil_pkg::*;

    // slots first, sink last
    localparam int NT = `AXIL_NUM_SLOTS + 1;

    logic [NT-1:0]  t_awready;
    logic [NT-1:0]  t_wready;
    logic [NT-1:0]  t_bvalid;
    logic [NT-1:0]  t_bready;
    resp_e          t_bresp [NT];
    logic [1:0]     sel_resp;

    genvar i;
    generate
        for (i = 0; i < `AXIL_NUM_SLOTS; i++)
        begin : g_link
            assign t_awready[i]        = slot_ports[i].awready;
            assign t_wready[i]         = slot_ports[i].wready;
            assign t_bvalid[i]         = slot_ports[i].bvalid;
            assign t_bresp[i]          = slot_ports[i].bresp;
            assign slot_ports[i].bready = t_bready[i];
        end
    endgenerate

    assign t_awready[NT-1] = sink_port.awready;
    assign t_wready[NT-1]  = sink_port.wready;
    assign t_bvalid[NT-1]  = sink_port.bvalid;
    assign t_bresp[NT-1]   = sink_port.bresp;
    assign sink_port.bready = t_bready[NT-1];

    // only one target is ever active
    assign awready = |t_awready;
    assign wready  = |t_wready;

    // take the response while the output register is empty
    assign t_bready = t_bvalid & {NT{!bvalid}};

    always_comb
    begin
        sel_resp = '0;
        for (int k = 0; k < NT; k++)
            if (t_bvalid[k])
                sel_resp = sel_resp | t_bresp[k];
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            bvalid <= 1'b0;
            bresp  <= OKAY;
        end
        else if (!bvalid && |t_bvalid)
        begin
            bvalid <= 1'b1;
            bresp  <= resp_e'(sel_resp);
        end
        else if (bvalid && bready)
        begin
            bvalid <= 1'b0;
            bresp  <= OKAY;
        end
    end

    assign resp_done = bvalid && bready;

endmodule

/* hw/axil_regfile_top.sv */
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_regfile_top
(
    input  logic                            aclk,
    input  logic                            aresetn,

    // write address
    input  logic [`AXIL_ADDR_WIDTH-1:0]     awaddr,
    input  logic                            awvalid,
    output logic                            awready,

    // write data
    input  axil_pkg::data_t                 wdata,
    input  axil_pkg::strb_t                 wstrb,
    input  logic                            wvalid,
    output logic                            wready,

    // write response
    output axil_pkg::resp_e                 bresp,
    output logic                            bvalid,
    input  logic                            bready,

    // slot 0 in the low bits
    output logic [`AXIL_NUM_SLOTS*`AXIL_REGS_PER_SLOT*`AXIL_DATA_WIDTH-1:0] ctrl_regs
);

    import regmap_pkg::*;

    localparam int SLOT_BITS = $bits(slot_regs_t);

    addr_u  aw_addr;
    logic   resp_done;

    axil_wr_if slot_link [`AXIL_NUM_SLOTS] ();
    axil_wr_if sink_link ();

    assign aw_addr.raw = awaddr;

    axil_wr_router u_router
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .awaddr     (aw_addr),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .resp_done  (resp_done),
        .slot_ports (slot_link),
        .sink_port  (sink_link)
    );

    genvar g;
    generate
        for (g = 0; g < `AXIL_NUM_SLOTS; g++)
        begin : g_slot
            axil_reg_slot u_slot
            (
                .aclk    (aclk),
                .aresetn (aresetn),
                .bus     (slot_link[g]),
                .regs    (ctrl_regs[g*SLOT_BITS +: SLOT_BITS])
            );
        end
    endgenerate

    axil_decerr_sink u_sink
    (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (sink_link)
    );

    axil_resp_slice u_slice
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .slot_ports (slot_link),
        .sink_port  (sink_link),
        .awready    (awready),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .resp_done  (resp_done)
    );

endmodule

/* test/tb_axil_regfile.sv */
`timescale 1ns/1ps
`include "axil_consts.svh"

module tb_axil_regfile;

    import axil_pkg::*;
    import regmap_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_WRITES = 42;
    localparam int WAIT_LIMIT = 20;
    localparam int NUM_WORDS  = `AXIL_NUM_SLOTS * `AXIL_REGS_PER_SLOT;

    logic                                   aclk;
    logic                                   aresetn;
    logic [`AXIL_ADDR_WIDTH-1:0]            awaddr;
    logic                                   awvalid;
    logic                                   awready;
    data_t                                  wdata;
    strb_t                                  wstrb;
    logic                                   wvalid;
    logic                                   wready;
    resp_e                                  bresp;
    logic                                   bvalid;
    logic                                   bready;
    logic [NUM_WORDS*`AXIL_DATA_WIDTH-1:0]  ctrl_regs;

    // expected register contents
    data_t          model [`AXIL_NUM_SLOTS][`AXIL_REGS_PER_SLOT];
    logic [31:0]    lfsr_state = 32'h33ca_4d09;
    int             checks = 0;
    int             errors = 0;

    axil_regfile_top uut
    (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .ctrl_regs (ctrl_regs)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // every write takes well under 20 cycles
    initial
    begin
        #((NUM_WRITES * WAIT_LIMIT + 100) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input logic [23:0] region, input int slot,
                                              input int idx);
        addr_u a;
        a.fields.region   = region;
        a.fields.slot     = slot[1:0];
        a.fields.reg_idx  = idx[3:0];
        a.fields.byte_off = 2'b00;
        return a.raw;
    endfunction

    function automatic resp_e expected_resp(input logic [23:0] region, input int idx);
        if (region != `AXIL_MAP_BASE)
            return DECERR;
        if (idx >= `AXIL_REGS_PER_SLOT)
            return SLVERR;
        return OKAY;
    endfunction

    // strobe bits widened to a bit mask over the word
    function automatic void model_write(input int slot, input int idx, input data_t data,
                                        input strb_t strb);
        data_t mask;
        mask = '0;
        for (int b = 0; b < `AXIL_DATA_WIDTH / 8; b++)
            mask[b*8 +: 8] = {8{strb[b]}};
        model[slot][idx] = (model[slot][idx] & ~mask) | (data & mask);
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_resp(input string name, input resp_e exp_val, input resp_e act);
        checks++;
        if (act !== exp_val)
        begin
            errors++;
            $display("[FAIL] %s: expected %s, actual %s (%b)", name, exp_val.name(),
                     act.name(), act);
        end
    endtask

    task automatic check_word(input string name, input data_t exp_val, input data_t act);
        checks++;
        if (act !== exp_val)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp_val, input int act);
        checks++;
        if (act != exp_val)
        begin
            errors++;
            $display("[FAIL] %s: expected %0d cycles, actual %0d", name, exp_val, act);
        end
    endtask

    task automatic check_regs(input string name);
        data_t act;
        for (int s = 0; s < `AXIL_NUM_SLOTS; s++)
            for (int r = 0; r < `AXIL_REGS_PER_SLOT; r++)
            begin
                act = ctrl_regs[(s*`AXIL_REGS_PER_SLOT + r)*`AXIL_DATA_WIDTH +: `AXIL_DATA_WIDTH];
                check_word($sformatf("%s slot %0d reg %0d", name, s, r), model[s][r], act);
            end
    endtask

    // --------------------------------------------------
    // bus driving
    // --------------------------------------------------
    task automatic start_write(input logic [31:0] addr, input data_t data, input strb_t strb);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
    endtask

    // counts falling edges until the ready pulse, then drops the valids
    task automatic wait_ready(output int lat);
        lat = 0;
        while (lat < WAIT_LIMIT && awready !== 1'b1)
        begin
            @(negedge aclk);
            lat++;
        end
        if (awready !== 1'b1)
            report_error("no awready pulse for the write");
        if (wready !== awready)
            report_error("awready and wready did not pulse together");
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    // readies must stay low once the pulse is over
    task automatic wait_bvalid(inout int lat);
        int n;
        n = 0;
        while (n < WAIT_LIMIT && bvalid !== 1'b1)
        begin
            @(negedge aclk);
            lat++;
            n++;
            if (awready !== 1'b0 || wready !== 1'b0)
                report_error("awready or wready stayed high for more than one cycle");
        end
        if (bvalid !== 1'b1)
            report_error("bvalid never rose for the write");
    endtask

    task automatic finish_resp();
        bready = 1'b1;
        @(negedge aclk);
        bready = 1'b0;
        if (bvalid !== 1'b0)
            report_error("bvalid still high after the B handshake");
    endtask

    task automatic run_write(input string name, input logic [23:0] region, input int slot,
                             input int idx, input data_t data, input strb_t strb);
        int     lat;
        resp_e  exp_resp;
        exp_resp = expected_resp(region, idx);
        @(negedge aclk);
        start_write(make_addr(region, slot, idx), data, strb);
        wait_ready(lat);
        check_cycles({name, " ready"}, 1, lat);
        wait_bvalid(lat);
        check_cycles({name, " bvalid"}, 3, lat);
        check_resp(name, exp_resp, bresp);
        finish_resp();
        if (exp_resp == OKAY)
            model_write(slot, idx, data, strb);
        check_regs(name);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_reset();
        if (awready !== 1'b0 || wready !== 1'b0 || bvalid !== 1'b0)
            report_error("readies or bvalid not low after reset");
        check_resp("reset bresp", OKAY, bresp);
        check_regs("reset");
    endtask

    task automatic test_full_words();
        for (int s = 0; s < `AXIL_NUM_SLOTS; s++)
            for (int r = 0; r < `AXIL_REGS_PER_SLOT; r++)
                run_write("full_word", `AXIL_MAP_BASE, s, r, rand_bits(32), '1);
    endtask

    task automatic test_partial_strobes();
        for (int i = 0; i < 16; i++)
            run_write("partial", `AXIL_MAP_BASE, int'(rand_bits(2)), int'(rand_bits(2)),
                      rand_bits(32), strb_t'(rand_bits(4)));
    endtask

    task automatic test_out_of_range();
        for (int s = 0; s < `AXIL_NUM_SLOTS; s++)
            run_write("out_of_range", `AXIL_MAP_BASE, s,
                      `AXIL_REGS_PER_SLOT + int'(rand_bits(3)), rand_bits(32), '1);
    endtask

    // one flipped region bit per write, spread over the whole field
    task automatic test_unmapped();
        for (int s = 0; s < `AXIL_NUM_SLOTS; s++)
            run_write("unmapped", `AXIL_MAP_BASE ^ (24'h1 << (s * 7)), s, s, rand_bits(32), '1);
    endtask

    task automatic test_back_pressure();
        int     lat;
        int     hold;
        data_t  d1;
        data_t  d2;
        strb_t  s2;
        d1   = rand_bits(32);
        d2   = rand_bits(32);
        s2   = strb_t'(rand_bits(4));
        hold = 2 + int'(rand_bits(3));
        @(negedge aclk);
        start_write(make_addr(`AXIL_MAP_BASE, 1, 9), d1, '1);
        wait_ready(lat);
        wait_bvalid(lat);
        check_resp("back_pressure first", SLVERR, bresp);
        // second write queued behind the pending response
        start_write(make_addr(`AXIL_MAP_BASE, 2, 3), d2, s2);
        for (int c = 0; c < hold; c++)
        begin
            @(negedge aclk);
            if (awready !== 1'b0 || wready !== 1'b0)
                report_error("second write accepted while the first response was pending");
            if (bvalid !== 1'b1)
                report_error("bvalid dropped without bready");
            check_resp("back_pressure hold", SLVERR, bresp);
        end
        finish_resp();
        wait_ready(lat);
        wait_bvalid(lat);
        check_resp("back_pressure second", OKAY, bresp);
        finish_resp();
        model_write(2, 3, d2, s2);
        check_regs("back_pressure");
    endtask

    initial
    begin
        aresetn = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        for (int s = 0; s < `AXIL_NUM_SLOTS; s++)
            for (int r = 0; r < `AXIL_REGS_PER_SLOT; r++)
                model[s][r] = '0;
        repeat (4) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        test_reset();
        test_full_words();
        test_partial_strobes();
        test_out_of_range();
        test_unmapped();
        test_back_pressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/axil_pkg.sv
hw/regmap_pkg.sv
hw/axil_wr_if.sv
hw/axil_wr_router.sv
hw/axil_reg_slot.sv
hw/axil_decerr_sink.sv
hw/axil_resp_slice.sv
hw/axil_regfile_top.sv
test/tb_axil_regfile.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG" \
    && verilator --binary --timing -Wno-fatal -f build.f \
        --top-module tb_axil_regfile -o tb_axil_regfile \
    && ./obj_dir/tb_axil_regfile 2>&1 | tee "$LOG" \
    || { echo "build or simulation run failed"; exit 1; }

# the log decides the result
grep -q '\*\*\* FAILED \*\*\*' "$LOG" && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
